// ==== serv_pkg.sv ====
package serv_pkg;

   localparam int XLEN  = 32;
   localparam int CNT_W = 5;

   localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

   // Major opcodes
   localparam logic [6:0] OP_OPIMM  = 7'b0010011;
   localparam logic [6:0] OP_OP     = 7'b0110011;
   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_JAL    = 7'b1101111;
   localparam logic [6:0] OP_STORE  = 7'b0100011;

   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;
   localparam logic [2:0] F3_BEQ = 3'b000;
   localparam logic [2:0] F3_BNE = 3'b001;
   localparam logic [2:0] F3_SW  = 3'b010;

   // funct7 of SUB, only bit 5 set
   localparam logic [6:0] F7_SUB = 7'b0100000;

   // Sequencer phases
   localparam logic [2:0] PH_FETCH     = 3'd0;
   localparam logic [2:0] PH_FETCH_REL = 3'd1;
   localparam logic [2:0] PH_EXEC      = 3'd2;
   localparam logic [2:0] PH_STORE     = 3'd3;
   localparam logic [2:0] PH_STORE_REL = 3'd4;

   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      // Immediate bits for I, S and B formats
      struct packed {
         logic [6:0] imm_hi;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] imm_lo;
         logic [6:0] opcode;
      } s;
   } insn_t;

endpackage

// ==== serv_state.sv ====
`timescale 1ns/10ps

module serv_state (
   input  logic                        clk,
   input  logic                        i_rst_n,
   input  logic                        i_ibus_ack,
   input  logic                        i_dbus_ack,
   input  logic                        i_is_store,
   output logic                        o_ibus_req,
   output logic                        o_dbus_req,
   output logic                        o_fetch_en,
   output logic                        o_cnt_en,
   output logic                        o_cnt_done,
   output logic [serv_pkg::CNT_W-1:0]  o_cnt
);

   logic [2:0] phase;

   assign o_cnt_en   = (phase == serv_pkg::PH_EXEC);
   assign o_cnt_done = o_cnt_en && (o_cnt == {serv_pkg::CNT_W{1'b1}});
   // Instruction word is taken on the first cycle ack is seen
   assign o_fetch_en = (phase == serv_pkg::PH_FETCH) && o_ibus_req && i_ibus_ack;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         phase      <= serv_pkg::PH_FETCH;
         o_ibus_req <= 1'b0;
         o_dbus_req <= 1'b0;
         o_cnt      <= '0;
      end else begin
         case (phase)
            serv_pkg::PH_FETCH: begin
               if (o_fetch_en) begin
                  o_ibus_req <= 1'b0;
                  phase      <= serv_pkg::PH_FETCH_REL;
               end else if (!o_ibus_req && !i_ibus_ack) begin
                  // First request out of reset
                  o_ibus_req <= 1'b1;
               end
            end
            serv_pkg::PH_FETCH_REL: begin
               if (!i_ibus_ack) begin
                  phase <= serv_pkg::PH_EXEC;
               end
            end
            serv_pkg::PH_EXEC: begin
               o_cnt <= o_cnt + 1'b1;
               if (o_cnt_done) begin
                  if (i_is_store) begin
                     o_dbus_req <= 1'b1;
                     phase      <= serv_pkg::PH_STORE;
                  end else begin
                     o_ibus_req <= 1'b1;
                     phase      <= serv_pkg::PH_FETCH;
                  end
               end
            end
            serv_pkg::PH_STORE: begin
               if (i_dbus_ack) begin
                  o_dbus_req <= 1'b0;
                  phase      <= serv_pkg::PH_STORE_REL;
               end
            end
            serv_pkg::PH_STORE_REL: begin
               if (!i_dbus_ack) begin
                  o_ibus_req <= 1'b1;
                  phase      <= serv_pkg::PH_FETCH;
               end
            end
            default: begin
               phase <= serv_pkg::PH_FETCH;
            end
         endcase
      end
   end

endmodule

// ==== serv_decode.sv ====
`timescale 1ns/10ps

module serv_decode (
   input  logic                        clk,
   input  logic                        i_rst_n,
   input  logic                        i_fetch_en,
   input  logic [31:0]                 i_ibus_rdt,
   input  logic [serv_pkg::CNT_W-1:0]  i_cnt,
   input  logic                        i_cnt_en,
   output logic [4:0]                  o_rs1_addr,
   output logic [4:0]                  o_rs2_addr,
   output logic [4:0]                  o_rd_addr,
   output logic                        o_rd_en,
   output logic                        o_imm,
   output logic                        o_alu_sub,
   output logic [1:0]                  o_alu_bool_op,
   output logic [1:0]                  o_alu_rd_sel,
   output logic                        o_op_b_imm,
   output logic                        o_is_branch,
   output logic                        o_branch_ne,
   output logic                        o_is_jal,
   output logic                        o_is_store,
   output logic                        o_is_lui
);

   serv_pkg::insn_t insn;
   logic [6:0]  opcode;
   logic [2:0]  f3;
   logic [6:0]  f7;
   logic        alu_f3;
   logic        is_opimm;
   logic        is_op;
   logic        sign;
   logic [31:0] imm_word;

   // Cleared to an all-zero word, which decodes as a no-operation
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         insn <= '0;
      end else if (i_fetch_en) begin
         insn <= i_ibus_rdt;
      end
   end

   assign opcode = insn.r.opcode;
   assign f3     = insn.r.funct3;
   assign f7     = insn.r.funct7;

   assign alu_f3   = (f3 == serv_pkg::F3_ADD) || (f3 == serv_pkg::F3_XOR) ||
                     (f3 == serv_pkg::F3_OR)  || (f3 == serv_pkg::F3_AND);
   assign is_opimm = (opcode == serv_pkg::OP_OPIMM) && alu_f3;
   assign is_op    = (opcode == serv_pkg::OP_OP) && alu_f3 &&
                     ((f7 == 7'd0) || ((f7 == serv_pkg::F7_SUB) && (f3 == serv_pkg::F3_ADD)));

   assign o_is_lui    = (opcode == serv_pkg::OP_LUI);
   assign o_is_jal    = (opcode == serv_pkg::OP_JAL);
   assign o_is_store  = (opcode == serv_pkg::OP_STORE) && (f3 == serv_pkg::F3_SW);
   assign o_is_branch = (opcode == serv_pkg::OP_BRANCH) &&
                        ((f3 == serv_pkg::F3_BEQ) || (f3 == serv_pkg::F3_BNE));
   assign o_branch_ne = (f3 == serv_pkg::F3_BNE);

   assign o_rs1_addr = insn.r.rs1;
   assign o_rs2_addr = insn.r.rs2;
   assign o_rd_addr  = insn.r.rd;
   assign o_rd_en    = (is_opimm || is_op || o_is_lui || o_is_jal) && (insn.r.rd != 5'd0);

   assign o_alu_sub     = is_op && (f7 == serv_pkg::F7_SUB);
   assign o_alu_bool_op = f3[1:0];
   // Bit 1 passes the immediate, bit 0 picks the boolean unit
   assign o_alu_rd_sel  = {o_is_lui, (is_opimm || is_op) && (f3 != serv_pkg::F3_ADD)};
   assign o_op_b_imm    = is_opimm || o_is_store;

   assign sign = insn.s.imm_hi[6];

   always_comb begin
      case (opcode)
         serv_pkg::OP_STORE: begin
            imm_word = {{20{sign}}, insn.s.imm_hi, insn.s.imm_lo};
         end
         serv_pkg::OP_BRANCH: begin
            imm_word = {{20{sign}}, insn.s.imm_lo[0], insn.s.imm_hi[5:0],
                        insn.s.imm_lo[4:1], 1'b0};
         end
         serv_pkg::OP_LUI: begin
            imm_word = {insn.s.imm_hi, insn.s.rs2, insn.s.rs1, insn.s.funct3, 12'h000};
         end
         serv_pkg::OP_JAL: begin
            imm_word = {{12{sign}}, insn.s.rs1, insn.s.funct3, insn.s.rs2[0],
                        insn.s.imm_hi[5:0], insn.s.rs2[4:1], 1'b0};
         end
         default: begin
            imm_word = {{20{sign}}, insn.s.imm_hi, insn.s.rs2};
         end
      endcase
   end

   // Quiet outside execute
   assign o_imm = i_cnt_en && imm_word[i_cnt];

endmodule

// ==== serv_alu.sv ====
`timescale 1ns/10ps

module serv_alu (
   input  logic       clk,
   input  logic       i_rst_n,
   input  logic       i_cnt_en,
   input  logic       i_cnt_done,
   input  logic       i_fetch_en,
   input  logic       i_rs1,
   input  logic       i_rs2,
   input  logic       i_imm,
   input  logic       i_op_b_imm,
   input  logic       i_sub,
   input  logic [1:0] i_bool_op,
   input  logic [1:0] i_rd_sel,
   output logic       o_rd,
   output logic       o_eq
);

   logic first;
   logic carry;
   logic eq_q;
   logic op_b;
   logic b_eff;
   logic cin;
   logic sum;
   logic bool_rd;

   assign op_b  = i_op_b_imm ? i_imm : i_rs2;
   assign b_eff = op_b ^ i_sub;
   // Subtraction adds the inverted operand with a carry in of one
   assign cin   = first ? i_sub : carry;
   assign sum   = i_rs1 ^ b_eff ^ cin;

   always_comb begin
      if (!i_bool_op[1]) begin
         bool_rd = i_rs1 ^ op_b;
      end else if (i_bool_op[0]) begin
         bool_rd = i_rs1 & op_b;
      end else begin
         bool_rd = i_rs1 | op_b;
      end
   end

   assign o_rd = i_rd_sel[1] ? i_imm : (i_rd_sel[0] ? bool_rd : sum);

   // Includes the current bit so the flag is complete at cnt_done
   assign o_eq = eq_q && !(i_rs1 ^ i_rs2);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         first <= 1'b1;
         eq_q  <= 1'b1;
      end else begin
         if (i_cnt_done) begin
            first <= 1'b1;
         end else if (i_cnt_en) begin
            first <= 1'b0;
         end
         if (i_fetch_en) begin
            eq_q <= 1'b1;
         end else if (i_cnt_en) begin
            eq_q <= o_eq;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry <= (i_rs1 & b_eff) | (cin & (i_rs1 ^ b_eff));
      end
   end

endmodule

// ==== serv_rf.sv ====
`timescale 1ns/10ps

module serv_rf (
   input  logic                        clk,
   input  logic [serv_pkg::CNT_W-1:0]  i_cnt,
   input  logic                        i_cnt_en,
   input  logic [4:0]                  i_rs1_addr,
   input  logic [4:0]                  i_rs2_addr,
   input  logic [4:0]                  i_rd_addr,
   input  logic                        i_rd_en,
   input  logic                        i_rd,
   output logic                        o_rs1,
   output logic                        o_rs2
);

   logic [31:0] regs [0:31];
   logic        wr_en;

   // x0 is never written
   assign wr_en = i_cnt_en && i_rd_en && (i_rd_addr != 5'd0);

   always_ff @(posedge clk) begin
      if (wr_en) begin
         regs[i_rd_addr][i_cnt] <= i_rd;
      end
   end

   // Bit cnt is read before its write lands, so rs may equal rd
   assign o_rs1 = (i_rs1_addr != 5'd0) && regs[i_rs1_addr][i_cnt];
   assign o_rs2 = (i_rs2_addr != 5'd0) && regs[i_rs2_addr][i_cnt];

endmodule

// ==== serv_ctrl.sv ====
`timescale 1ns/10ps

module serv_ctrl (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic                       i_cnt_en,
   input  logic                       i_cnt_done,
   input  logic                       i_imm,
   input  logic                       i_is_branch,
   input  logic                       i_branch_ne,
   input  logic                       i_eq,
   input  logic                       i_is_jal,
   output logic [serv_pkg::XLEN-1:0]  o_ibus_adr,
   output logic                       o_rd
);

   logic [serv_pkg::XLEN-1:0] pc;
   logic [serv_pkg::XLEN-1:0] pc4_q;
   logic [serv_pkg::XLEN-1:0] pci_q;
   logic [serv_pkg::XLEN-1:0] pc4_next;
   logic [serv_pkg::XLEN-1:0] pci_next;
   logic [2:0]                four;
   logic                      c4;
   logic                      ci;
   logic                      s4;
   logic                      si;
   logic                      take;

   // PC bits leave at bit 0 while sums enter at the top
   assign s4       = pc4_q[0] ^ four[0] ^ c4;
   assign si       = pci_q[0] ^ i_imm ^ ci;
   assign pc4_next = {s4, pc4_q[serv_pkg::XLEN-1:1]};
   assign pci_next = {si, pci_q[serv_pkg::XLEN-1:1]};

   assign take = i_is_jal || (i_is_branch && (i_eq ^ i_branch_ne));

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc    <= serv_pkg::RESET_PC;
         pc4_q <= serv_pkg::RESET_PC;
         pci_q <= serv_pkg::RESET_PC;
         c4    <= 1'b0;
         ci    <= 1'b0;
         four  <= 3'b100;
      end else if (i_cnt_done) begin
         pc    <= take ? pci_next : pc4_next;
         pc4_q <= take ? pci_next : pc4_next;
         pci_q <= take ? pci_next : pc4_next;
         c4    <= 1'b0;
         ci    <= 1'b0;
         four  <= 3'b100;
      end else if (i_cnt_en) begin
         pc4_q <= pc4_next;
         pci_q <= pci_next;
         c4    <= (pc4_q[0] & four[0]) | (c4 & (pc4_q[0] ^ four[0]));
         ci    <= (pci_q[0] & i_imm) | (ci & (pci_q[0] ^ i_imm));
         four  <= four >> 1;
      end
   end

   assign o_ibus_adr = pc;
   // Link value for JAL
   assign o_rd = s4;

endmodule

// ==== serv_mem_if.sv ====
`timescale 1ns/10ps

module serv_mem_if (
   input  logic                       clk,
   input  logic                       i_cnt_en,
   input  logic                       i_is_store,
   input  logic                       i_alu_rd,
   input  logic                       i_rs2,
   output logic [serv_pkg::XLEN-1:0]  o_dbus_adr,
   output logic [serv_pkg::XLEN-1:0]  o_dbus_dat
);

   logic shift_en;

   assign shift_en = i_cnt_en && i_is_store;

   // Filled lsb first, held through the bus handshake
   always_ff @(posedge clk) begin
      if (shift_en) begin
         o_dbus_adr <= {i_alu_rd, o_dbus_adr[serv_pkg::XLEN-1:1]};
         o_dbus_dat <= {i_rs2, o_dbus_dat[serv_pkg::XLEN-1:1]};
      end
   end

endmodule

// ==== serv_top.sv ====
`timescale 1ns/10ps

module serv_top (
   input  logic                       clk,
   input  logic                       i_rst_n,
   output logic                       o_ibus_req,
   output logic [serv_pkg::XLEN-1:0]  o_ibus_adr,
   input  logic                       i_ibus_ack,
   input  logic [serv_pkg::XLEN-1:0]  i_ibus_rdt,
   output logic                       o_dbus_req,
   output logic [serv_pkg::XLEN-1:0]  o_dbus_adr,
   output logic [serv_pkg::XLEN-1:0]  o_dbus_dat,
   input  logic                       i_dbus_ack
);

   logic [serv_pkg::CNT_W-1:0] cnt;
   logic       cnt_en;
   logic       cnt_done;
   logic       fetch_en;
   logic [4:0] rs1_addr;
   logic [4:0] rs2_addr;
   logic [4:0] rd_addr;
   logic       rd_en;
   logic       imm;
   logic       alu_sub;
   logic [1:0] alu_bool_op;
   logic [1:0] alu_rd_sel;
   logic       op_b_imm;
   logic       is_branch;
   logic       branch_ne;
   logic       is_jal;
   logic       is_store;
   logic       rs1;
   logic       rs2;
   logic       alu_rd;
   logic       eq;
   logic       ctrl_rd;
   logic       rd;

   assign rd = is_jal ? ctrl_rd : alu_rd;

   serv_state state (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .i_is_store (is_store),
      .o_ibus_req (o_ibus_req),
      .o_dbus_req (o_dbus_req),
      .o_fetch_en (fetch_en),
      .o_cnt_en   (cnt_en),
      .o_cnt_done (cnt_done),
      .o_cnt      (cnt)
   );

   serv_decode decode (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_fetch_en    (fetch_en),
      .i_ibus_rdt    (i_ibus_rdt),
      .i_cnt         (cnt),
      .i_cnt_en      (cnt_en),
      .o_rs1_addr    (rs1_addr),
      .o_rs2_addr    (rs2_addr),
      .o_rd_addr     (rd_addr),
      .o_rd_en       (rd_en),
      .o_imm         (imm),
      .o_alu_sub     (alu_sub),
      .o_alu_bool_op (alu_bool_op),
      .o_alu_rd_sel  (alu_rd_sel),
      .o_op_b_imm    (op_b_imm),
      .o_is_branch   (is_branch),
      .o_branch_ne   (branch_ne),
      .o_is_jal      (is_jal),
      .o_is_store    (is_store),
      .o_is_lui      ()
   );

   serv_alu alu (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt_en   (cnt_en),
      .i_cnt_done (cnt_done),
      .i_fetch_en (fetch_en),
      .i_rs1      (rs1),
      .i_rs2      (rs2),
      .i_imm      (imm),
      .i_op_b_imm (op_b_imm),
      .i_sub      (alu_sub),
      .i_bool_op  (alu_bool_op),
      .i_rd_sel   (alu_rd_sel),
      .o_rd       (alu_rd),
      .o_eq       (eq)
   );

   serv_rf rf (
      .clk        (clk),
      .i_cnt      (cnt),
      .i_cnt_en   (cnt_en),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_rd_en    (rd_en),
      .i_rd       (rd),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   serv_ctrl ctrl (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_cnt_en    (cnt_en),
      .i_cnt_done  (cnt_done),
      .i_imm       (imm),
      .i_is_branch (is_branch),
      .i_branch_ne (branch_ne),
      .i_eq        (eq),
      .i_is_jal    (is_jal),
      .o_ibus_adr  (o_ibus_adr),
      .o_rd        (ctrl_rd)
   );

   serv_mem_if mem_if (
      .clk        (clk),
      .i_cnt_en   (cnt_en),
      .i_is_store (is_store),
      .i_alu_rd   (alu_rd),
      .i_rs2      (rs2),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat)
   );

endmodule

// ==== tb_serv_top.sv ====
`timescale 1ns/10ps

module tb_serv_top;

   localparam int MEM_WORDS = 512;
   localparam int TIMEOUT   = 200;
   localparam int IDLE_MAX  = 20000;
   localparam int MAX_INSNS = 2000;

   logic                      clk;
   logic                      i_rst_n;
   logic                      o_ibus_req;
   logic [serv_pkg::XLEN-1:0] o_ibus_adr;
   logic                      i_ibus_ack;
   logic [serv_pkg::XLEN-1:0] i_ibus_rdt;
   logic                      o_dbus_req;
   logic [serv_pkg::XLEN-1:0] o_dbus_adr;
   logic [serv_pkg::XLEN-1:0] o_dbus_dat;
   logic                      i_dbus_ack;

   logic [31:0] imem [0:MEM_WORDS-1];
   int          wp;
   logic [31:0] end_pc;
   logic [31:0] rng = 32'hd064;
   logic [31:0] fetch_q [$];
   logic [31:0] st_adr_q [$];
   logic [31:0] st_dat_q [$];

   // Reference ISS state
   logic [31:0] ref_regs [0:31];
   logic [31:0] ref_pc;
   logic        ref_store;
   logic [31:0] ref_st_adr;
   logic [31:0] ref_st_dat;

   serv_top dut (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .o_ibus_req (o_ibus_req),
      .o_ibus_adr (o_ibus_adr),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .o_dbus_req (o_dbus_req),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .i_dbus_ack (i_dbus_ack)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32();
      logic [31:0] x;
      x = rng;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng = x;
      return x;
   endfunction

   task automatic stop_failed();
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic report_error(input string why);
      $display("%s", why);
      stop_failed();
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         stop_failed();
      end
   endtask

   task automatic wait_ibus_req(input logic level, input int limit);
      int t;
      t = 0;
      while (o_ibus_req !== level) begin
         @(posedge clk);
         #1;
         t++;
         if (t > limit) report_error("instruction bus request did not change in time");
      end
   endtask

   task automatic wait_dbus_req(input logic level, input int limit);
      int t;
      t = 0;
      while (o_dbus_req !== level) begin
         @(posedge clk);
         #1;
         t++;
         if (t > limit) report_error("data bus request did not change in time");
      end
   endtask

   task automatic wait_fetch();
      int t;
      t = 0;
      while (fetch_q.size() == 0) begin
         @(posedge clk);
         t++;
         if (t > TIMEOUT) report_error("no instruction fetch arrived in time");
      end
   endtask

   task automatic wait_store();
      int t;
      t = 0;
      while (st_adr_q.size() == 0) begin
         @(posedge clk);
         t++;
         if (t > TIMEOUT) report_error("an expected store never arrived");
      end
   endtask

   function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] op);
      return {f7, rs2, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], serv_pkg::OP_STORE};
   endfunction

   function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], serv_pkg::OP_BRANCH};
   endfunction

   function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, serv_pkg::OP_LUI};
   endfunction

   function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, serv_pkg::OP_JAL};
   endfunction

   function automatic void put(input logic [31:0] w);
      imem[wp] = w;
      wp++;
   endfunction

   function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                           input logic [31:0] a, input logic [31:0] b);
      case (f3)
         serv_pkg::F3_XOR: return a ^ b;
         serv_pkg::F3_OR:  return a | b;
         serv_pkg::F3_AND: return a & b;
         default:          return sub ? a - b : a + b;
      endcase
   endfunction

   // Anything outside the subset steps as a no-operation
   function automatic void ref_step(input logic [31:0] w);
      logic [2:0]  f3;
      logic [6:0]  f7;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [31:0] next;
      logic        alu_f3;
      logic        wr;
      f3 = w[14:12];
      f7 = w[31:25];
      a = ref_regs[w[19:15]];
      b = ref_regs[w[24:20]];
      alu_f3 = (f3 == 3'b000) || (f3 == 3'b100) || (f3 == 3'b110) || (f3 == 3'b111);
      next = ref_pc + 4;
      res = '0;
      wr = 1'b0;
      ref_store = 1'b0;
      case (w[6:0])
         serv_pkg::OP_OPIMM: begin
            wr = alu_f3;
            res = alu_ref(f3, 1'b0, a, {{20{w[31]}}, w[31:20]});
         end
         serv_pkg::OP_OP: begin
            wr = (f7 == 7'd0 && alu_f3) || (f7 == 7'b0100000 && f3 == 3'b000);
            res = alu_ref(f3, f7[5], a, b);
         end
         serv_pkg::OP_LUI: begin
            wr = 1'b1;
            res = {w[31:12], 12'h000};
         end
         serv_pkg::OP_JAL: begin
            wr = 1'b1;
            res = ref_pc + 4;
            next = ref_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
         end
         serv_pkg::OP_BRANCH: begin
            if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
               next = ref_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
         end
         serv_pkg::OP_STORE: begin
            ref_store = (f3 == 3'b010);
            ref_st_adr = a + {{20{w[31]}}, w[31:25], w[11:7]};
            ref_st_dat = b;
         end
         default: begin
         end
      endcase
      if (wr && w[11:7] != 5'd0) ref_regs[w[11:7]] = res;
      ref_pc = next;
   endfunction

   task automatic build_program();
      int          i;
      int          sel;
      logic [31:0] r;
      logic [4:0]  rd;
      for (i = 0; i < MEM_WORDS; i++) begin
         // Custom-0 opcode word that carries its own index
         imem[i] = {i[24:0], 7'b0001011};
      end
      wp = 0;
      for (i = 1; i < 32; i++) begin
         r = xorshift32();
         put(i_type(r[11:0], 5'd0, serv_pkg::F3_ADD, i[4:0], serv_pkg::OP_OPIMM));
      end
      for (i = 0; i < 40; i++) begin
         r = xorshift32();
         rd = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
         sel = xorshift32() % 6;
         case (sel)
            0: put(i_type(r[31:20], r[9:5], serv_pkg::F3_ADD, rd, serv_pkg::OP_OPIMM));
            1: put(r_type(7'd0, r[14:10], r[9:5], serv_pkg::F3_ADD, rd, serv_pkg::OP_OP));
            2: put(r_type(serv_pkg::F7_SUB, r[14:10], r[9:5], serv_pkg::F3_ADD, rd,
                          serv_pkg::OP_OP));
            default: begin
               if (r[15]) put(r_type(7'd0, r[14:10], r[9:5], sel == 3 ? serv_pkg::F3_AND :
                                     sel == 4 ? serv_pkg::F3_OR : serv_pkg::F3_XOR, rd,
                                     serv_pkg::OP_OP));
               else put(i_type(r[31:20], r[9:5], sel == 3 ? serv_pkg::F3_AND :
                               sel == 4 ? serv_pkg::F3_OR : serv_pkg::F3_XOR, rd,
                               serv_pkg::OP_OPIMM));
            end
         endcase
         r = xorshift32();
         put(s_type(r[31:20], rd, r[4:0], serv_pkg::F3_SW));
      end
      // Full constants from LUI and a negative ADDI
      for (i = 0; i < 4; i++) begin
         r = xorshift32();
         rd = (r[4:0] == 5'd0) ? 5'd3 : r[4:0];
         put(u_type(r[31:12], rd));
         put(i_type({1'b1, r[10:0]}, rd, serv_pkg::F3_ADD, rd, serv_pkg::OP_OPIMM));
         put(s_type(r[11:0], rd, 5'd0, serv_pkg::F3_SW));
      end
      // Forward branches that skip a store when taken
      for (i = 0; i < 12; i++) begin
         r = xorshift32();
         put(b_type(13'd8, r[5] ? r[4:0] : r[10:6], r[4:0],
                    r[11] ? serv_pkg::F3_BNE : serv_pkg::F3_BEQ));
         put(s_type(r[31:20], r[4:0], 5'd0, serv_pkg::F3_SW));
      end
      // BNE loop with three passes
      put(i_type(12'd3, 5'd0, serv_pkg::F3_ADD, 5'd5, serv_pkg::OP_OPIMM));
      put(i_type(12'hfff, 5'd5, serv_pkg::F3_ADD, 5'd5, serv_pkg::OP_OPIMM));
      put(s_type(12'h040, 5'd5, 5'd0, serv_pkg::F3_SW));
      put(b_type(-13'sd8, 5'd0, 5'd5, serv_pkg::F3_BNE));
      // BEQ loop taken once backwards
      put(i_type(12'd0, 5'd0, serv_pkg::F3_ADD, 5'd7, serv_pkg::OP_OPIMM));
      put(i_type(12'd1, 5'd7, serv_pkg::F3_ADD, 5'd7, serv_pkg::OP_OPIMM));
      put(i_type(12'hfff, 5'd7, serv_pkg::F3_ADD, 5'd8, serv_pkg::OP_OPIMM));
      put(b_type(-13'sd8, 5'd0, 5'd8, serv_pkg::F3_BEQ));
      put(s_type(12'h044, 5'd7, 5'd0, serv_pkg::F3_SW));
      // JAL link value then a plain jump
      put(j_type(21'd12, 5'd9));
      put(s_type(12'h7f0, 5'd1, 5'd0, serv_pkg::F3_SW));
      put(s_type(12'h7f4, 5'd2, 5'd0, serv_pkg::F3_SW));
      put(s_type(12'h010, 5'd9, 5'd0, serv_pkg::F3_SW));
      put(j_type(21'd8, 5'd0));
      put(s_type(12'h7f8, 5'd1, 5'd0, serv_pkg::F3_SW));
      // x0 stays zero
      put(i_type(12'd5, 5'd1, serv_pkg::F3_ADD, 5'd0, serv_pkg::OP_OPIMM));
      put(r_type(7'd0, 5'd2, 5'd1, serv_pkg::F3_ADD, 5'd0, serv_pkg::OP_OP));
      put(u_type(20'habcde, 5'd0));
      put(s_type(12'h020, 5'd0, 5'd0, serv_pkg::F3_SW));
      // Unsupported SLLI, SLT, MUL, LW, SB, BLT and a zero word
      put(i_type(12'd3, 5'd1, 3'b001, 5'd1, serv_pkg::OP_OPIMM));
      put(r_type(7'd0, 5'd3, 5'd2, 3'b010, 5'd1, serv_pkg::OP_OP));
      put(r_type(7'd1, 5'd3, 5'd2, serv_pkg::F3_ADD, 5'd1, serv_pkg::OP_OP));
      put(i_type(12'd0, 5'd0, 3'b010, 5'd1, 7'b0000011));
      put(s_type(12'h030, 5'd2, 5'd0, 3'b000));
      put(b_type(13'd8, 5'd2, 5'd1, 3'b100));
      put(32'h0000_0000);
      put(s_type(12'h034, 5'd1, 5'd0, serv_pkg::F3_SW));
      end_pc = wp * 4;
      put(j_type(21'd0, 5'd0));
   endtask

   initial begin : main
      i_rst_n = 1'b0;
      i_ibus_ack = 1'b0;
      i_ibus_rdt = '0;
      i_dbus_ack = 1'b0;
      build_program();
      repeat (8) begin
         @(posedge clk);
         #1;
         check("o_ibus_req", o_ibus_req, 1'b0);
         check("o_dbus_req", o_dbus_req, 1'b0);
      end
      i_rst_n = 1'b1;
      @(posedge clk);
      #1;
      check("o_ibus_req", o_ibus_req, 1'b1);
      check("o_ibus_adr", o_ibus_adr, serv_pkg::RESET_PC);
   end

   initial begin : ibus_model
      logic [31:0] adr;
      int          d;
      forever begin
         wait_ibus_req(1'b1, TIMEOUT);
         adr = o_ibus_adr;
         fetch_q.push_back(adr);
         d = xorshift32() % 4;
         repeat (d) begin
            @(posedge clk);
            #1;
            check("o_ibus_req", o_ibus_req, 1'b1);
            check("o_ibus_adr", o_ibus_adr, adr);
         end
         i_ibus_rdt = imem[adr[10:2]];
         i_ibus_ack = 1'b1;
         wait_ibus_req(1'b0, TIMEOUT);
         d = xorshift32() % 4;
         repeat (d) begin
            @(posedge clk);
            #1;
         end
         i_ibus_ack = 1'b0;
         i_ibus_rdt = xorshift32();
      end
   end

   initial begin : dbus_model
      logic [31:0] adr;
      logic [31:0] dat;
      int          d;
      forever begin
         wait_dbus_req(1'b1, IDLE_MAX);
         adr = o_dbus_adr;
         dat = o_dbus_dat;
         st_adr_q.push_back(adr);
         st_dat_q.push_back(dat);
         d = xorshift32() % 4;
         repeat (d) begin
            @(posedge clk);
            #1;
            check("o_dbus_req", o_dbus_req, 1'b1);
            check("o_dbus_adr", o_dbus_adr, adr);
            check("o_dbus_dat", o_dbus_dat, dat);
         end
         i_dbus_ack = 1'b1;
         wait_dbus_req(1'b0, TIMEOUT);
         d = xorshift32() % 4;
         repeat (d) begin
            @(posedge clk);
            #1;
         end
         i_dbus_ack = 1'b0;
      end
   end

   initial begin : compare
      logic [31:0] adr;
      int          i;
      int          n;
      bit          done;
      for (i = 0; i < 32; i++) begin
         ref_regs[i] = '0;
      end
      ref_pc = serv_pkg::RESET_PC;
      n = 0;
      done = 1'b0;
      while (!done) begin
         wait_fetch();
         adr = fetch_q.pop_front();
         if (st_adr_q.size() != 0) report_error("the DUT made a store the ISS did not expect");
         check("o_ibus_adr", adr, ref_pc);
         if (ref_pc == end_pc) begin
            done = 1'b1;
         end else begin
            ref_step(imem[ref_pc[10:2]]);
            if (ref_store) begin
               wait_store();
               check("o_dbus_adr", st_adr_q.pop_front(), ref_st_adr);
               check("o_dbus_dat", st_dat_q.pop_front(), ref_st_dat);
            end
            n++;
            if (n > MAX_INSNS) report_error("program did not reach its final instruction");
         end
      end
      $display("Test OK");
      $finish;
   end

endmodule

// ==== serv_top.f ====
serv_pkg.sv
serv_state.sv
serv_decode.sv
serv_alu.sv
serv_rf.sv
serv_ctrl.sv
serv_mem_if.sv
serv_top.sv
tb_serv_top.sv
